//--- Bender.yml
package:
  name: core

sources:
  - source/core_pkg.sv
  - source/core_ifu.sv
  - source/core_idu.sv
  - source/core_rf.sv
  - source/core_exu.sv
  - source/core_top.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/core_tb.sv

//--- project.f
source/core_pkg.sv
source/core_ifu.sv
source/core_idu.sv
source/core_rf.sv
source/core_exu.sv
source/core_top.sv
tb/tb_clock.sv
tb/core_tb.sv

//--- source/core_exu.sv
`timescale 1ns/1ns

module core_exu (
    input  logic                            arst_n,
    input  logic                            halted,
    input  logic [core_pkg::XLEN-1:0]       src1,
    input  logic [core_pkg::XLEN-1:0]       src2,
    input  logic [core_pkg::REG_ADDR_W-1:0] rd,
    input  logic [core_pkg::CMD_W-1:0]      command,
    output logic                            wb_en,
    output logic [core_pkg::REG_ADDR_W-1:0] wb_addr,
    output logic [core_pkg::XLEN-1:0]       wb_data,
    output logic                            halt_req
);

    logic writes_rd;

    always_comb begin
        case (command)
            core_pkg::CMD_ADD: wb_data = src1 + src2;
            core_pkg::CMD_EQU: wb_data = src1;
            default:           wb_data = '0;
        endcase
    end

    assign writes_rd = (command == core_pkg::CMD_ADD) || (command == core_pkg::CMD_EQU);

    // quiet in reset and after halt.
    assign wb_en   = arst_n && !halted && writes_rd && (rd != '0);
    assign wb_addr = rd;

    assign halt_req = (command == core_pkg::CMD_HALT);

endmodule

//--- source/core_idu.sv
`timescale 1ns/1ns

module core_idu (
    input  logic [core_pkg::XLEN-1:0]       inst,
    input  logic [core_pkg::XLEN-1:0]       pc,
    input  logic [core_pkg::XLEN-1:0]       rdata1,
    output logic [core_pkg::REG_ADDR_W-1:0] raddr1,
    output logic [core_pkg::REG_ADDR_W-1:0] raddr2,
    output logic [core_pkg::XLEN-1:0]       src1,
    output logic [core_pkg::XLEN-1:0]       src2,
    output logic [core_pkg::REG_ADDR_W-1:0] rd,
    output logic [core_pkg::CMD_W-1:0]      command
);

    logic [6:0]                      opcode;
    logic [2:0]                      funct3;
    logic [core_pkg::REG_ADDR_W-1:0] rs1_field;
    logic [core_pkg::REG_ADDR_W-1:0] rd_field;
    logic [2:0]                      imm_kind;
    logic [core_pkg::XLEN-1:0]       imm;
    logic                            rs1_en;
    logic                            rd_en;

    assign opcode    = inst[6:0];
    assign funct3    = inst[14:12];
    assign rs1_field = inst[19:15];
    assign rd_field  = inst[11:7];

    assign raddr1 = rs1_en ? rs1_field : '0;
    // no supported op reads rs2.
    assign raddr2 = '0;
    assign rd     = rd_en ? rd_field : '0;

    always_comb begin
        case (imm_kind)
            core_pkg::IMM_I: imm = {{20{inst[31]}}, inst[31:20]};
            core_pkg::IMM_U: imm = {inst[31:12], 12'b0};
            default:         imm = '0;
        endcase
    end

    always_comb begin
        // nop unless a case below says otherwise.
        imm_kind = core_pkg::IMM_N;
        command  = core_pkg::CMD_NOP;
        src1     = '0;
        src2     = '0;
        rs1_en   = 1'b0;
        rd_en    = 1'b0;

        case (opcode)
            core_pkg::OP_IMM: begin
                // only addi, other funct3 stay nop.
                if (funct3 == core_pkg::F3_ADDI) begin
                    imm_kind = core_pkg::IMM_I;
                    command  = core_pkg::CMD_ADD;
                    src1     = imm;
                    src2     = rdata1;
                    rs1_en   = 1'b1;
                    rd_en    = 1'b1;
                end
            end
            core_pkg::OP_LUI: begin
                imm_kind = core_pkg::IMM_U;
                command  = core_pkg::CMD_EQU;
                src1     = imm;
                rd_en    = 1'b1;
            end
            core_pkg::OP_AUIPC: begin
                imm_kind = core_pkg::IMM_U;
                command  = core_pkg::CMD_ADD;
                src1     = pc;
                src2     = imm;
                rd_en    = 1'b1;
            end
            core_pkg::OP_SYSTEM: begin
                command = core_pkg::CMD_HALT;
            end
            default: begin
            end
        endcase
    end

    // every decode path lands on a known command.
    always_comb begin
        a_cmd_legal: assert final (command inside {
            core_pkg::CMD_NOP, core_pkg::CMD_ADD,
            core_pkg::CMD_EQU, core_pkg::CMD_HALT
        });
    end

endmodule

//--- source/core_ifu.sv
`timescale 1ns/1ns

module core_ifu (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      halt_req,
    output logic [core_pkg::XLEN-1:0] pc,
    output logic                      halted
);

    logic [core_pkg::XLEN-1:0] pc_next;

    // pc holds on the halting edge and ever after.
    assign pc_next = (halt_req || halted) ? pc : pc + 4;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc     <= core_pkg::RESET_PC;
            halted <= 1'b0;
        end else begin
            pc <= pc_next;
            if (halt_req) begin
                halted <= 1'b1;
            end
        end
    end

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!arst_n)
        pc[1:0] == 2'b00
    );

    // no fetch progress after halt.
    a_pc_frozen: assert property (
        @(posedge clk) disable iff (!arst_n)
        halted |=> $stable(pc)
    );

endmodule

//--- source/core_pkg.sv
package core_pkg;

    // datapath and instruction width.
    localparam int XLEN = 32;

    // register file address width.
    localparam int REG_ADDR_W = 5;

    // execute command width.
    localparam int CMD_W = 4;

    // first fetch address.
    localparam logic [XLEN-1:0] RESET_PC = '0;

    // major opcodes known to the decoder.
    localparam logic [6:0] OP_IMM    = 7'b00100_11;
    localparam logic [6:0] OP_LUI    = 7'b01101_11;
    localparam logic [6:0] OP_AUIPC  = 7'b00101_11;
    localparam logic [6:0] OP_SYSTEM = 7'b11100_11;

    // funct3 of addi.
    localparam logic [2:0] F3_ADDI = 3'b000;

    // commands handed from decode to execute.
    localparam logic [CMD_W-1:0] CMD_NOP  = 4'd0;
    localparam logic [CMD_W-1:0] CMD_ADD  = 4'd1;
    localparam logic [CMD_W-1:0] CMD_EQU  = 4'd2;
    localparam logic [CMD_W-1:0] CMD_HALT = 4'd3;

    // immediate kinds, one-hot.
    localparam logic [2:0] IMM_I = 3'b001;
    localparam logic [2:0] IMM_U = 3'b010;
    localparam logic [2:0] IMM_N = 3'b100;

endpackage

//--- source/core_rf.sv
`timescale 1ns/1ns

module core_rf (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr1,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr2,
    output logic [core_pkg::XLEN-1:0]       rdata1,
    output logic [core_pkg::XLEN-1:0]       rdata2,
    input  logic                            we,
    input  logic [core_pkg::REG_ADDR_W-1:0] waddr,
    input  logic [core_pkg::XLEN-1:0]       wdata
);

    logic [core_pkg::XLEN-1:0] regs [0:(1<<core_pkg::REG_ADDR_W)-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < (1 << core_pkg::REG_ADDR_W); i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero.
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    a_x0_zero: assert property (
        @(posedge clk) disable iff (!arst_n)
        (raddr1 == '0) |-> (rdata1 == '0)
    );

endmodule

//--- source/core_top.sv
`timescale 1ns/1ns

module core_top (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [core_pkg::XLEN-1:0]       inst,
    output logic [core_pkg::XLEN-1:0]       pc,
    output logic                            wb_en,
    output logic [core_pkg::REG_ADDR_W-1:0] wb_addr,
    output logic [core_pkg::XLEN-1:0]       wb_data,
    output logic                            halted
);

    logic                            halt_req;
    logic [core_pkg::REG_ADDR_W-1:0] raddr1;
    logic [core_pkg::REG_ADDR_W-1:0] raddr2;
    logic [core_pkg::XLEN-1:0]       rdata1;
    logic [core_pkg::XLEN-1:0]       src1;
    logic [core_pkg::XLEN-1:0]       src2;
    logic [core_pkg::REG_ADDR_W-1:0] rd;
    logic [core_pkg::CMD_W-1:0]      command;

    core_ifu core_ifu_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .halt_req (halt_req),
        .pc       (pc),
        .halted   (halted)
    );

    core_idu core_idu_i (
        .inst    (inst),
        .pc      (pc),
        .rdata1  (rdata1),
        .raddr1  (raddr1),
        .raddr2  (raddr2),
        .src1    (src1),
        .src2    (src2),
        .rd      (rd),
        .command (command)
    );

    // second read port left open.
    core_rf core_rf_i (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (),
        .we     (wb_en),
        .waddr  (wb_addr),
        .wdata  (wb_data)
    );

    core_exu core_exu_i (
        .arst_n   (arst_n),
        .halted   (halted),
        .src1     (src1),
        .src2     (src2),
        .rd       (rd),
        .command  (command),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data),
        .halt_req (halt_req)
    );

endmodule

//--- tb/core_tb.sv
`timescale 1ns/1ns

module core_tb;

    localparam int CLK_PERIOD = 10;
    localparam int DRIVE_DLY = 1;
    localparam int SAMPLE_DLY = 7;
    localparam int NUM_RAND = 40;
    localparam int HALT_TAIL = 4;

    // instruction encodings for the stimulus.
    localparam logic [6:0] OPC_LUI = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [31:0] EBREAK = 32'h0010_0073;

    logic                                clk;
    logic                                arst_n;
    logic [core_pkg::XLEN-1:0]           inst;
    logic [core_pkg::XLEN-1:0]           pc;
    logic                                wb_en;
    logic [core_pkg::REG_ADDR_W-1:0]     wb_addr;
    logic [core_pkg::XLEN-1:0]           wb_data;
    logic                                halted;

    // program table, one row per instruction.
    logic [31:0] tbl_inst [$];
    string       tbl_name [$];
    logic        tbl_en [$];
    logic [4:0]  tbl_addr [$];
    logic [31:0] tbl_data [$];

    // register model for the random phase.
    logic [31:0] model [0:31];

    integer      seed;
    logic [31:0] rnd;
    logic [4:0]  r_rd;
    logic [4:0]  r_rs1;
    logic [11:0] r_imm;
    logic [31:0] exp_pc;
    logic [31:0] exp_data;
    logic [31:0] halt_pc;
    int          idx;
    bit          table_ready;

    tb_clock tb_clock_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    core_top core_top_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .inst    (inst),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data),
        .halted  (halted)
    );

    function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_upper(input logic [6:0] opcode, input logic [4:0] rd,
                                              input logic [19:0] imm);
        return {imm, rd, opcode};
    endfunction

    task automatic add_row(input logic [31:0] word, input string name, input logic en,
                           input logic [4:0] addr, input logic [31:0] data);
        tbl_inst.push_back(word);
        tbl_name.push_back(name);
        tbl_en.push_back(en);
        tbl_addr.push_back(addr);
        tbl_data.push_back(data);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "check failed");
        end
    endtask

    task automatic check_outputs(input string name, input logic [31:0] pc_exp,
                                 input logic halt_exp, input logic en_exp,
                                 input logic [4:0] addr_exp, input logic [31:0] data_exp);
        check_value({name, " pc"}, pc_exp, pc);
        check_value({name, " halted"}, {31'b0, halt_exp}, {31'b0, halted});
        check_value({name, " wb_en"}, {31'b0, en_exp}, {31'b0, wb_en});
        if (en_exp) begin
            check_value({name, " wb_addr"}, {27'b0, addr_exp}, {27'b0, wb_addr});
            check_value({name, " wb_data"}, data_exp, wb_data);
        end
    endtask

    // expected pc of row i is 4*i.
    task automatic build_table();
        add_row(enc_upper(OPC_LUI, 5'd1, 20'h12345), "lui_x1", 1'b1, 5'd1, 32'h1234_5000);
        add_row(enc_upper(OPC_AUIPC, 5'd2, 20'h00001), "auipc_x2", 1'b1, 5'd2, 32'h0000_1004);
        add_row(enc_addi(5'd3, 5'd1, 12'h7ff), "addi_pos", 1'b1, 5'd3, 32'h1234_57ff);
        add_row(enc_addi(5'd4, 5'd3, 12'hfff), "addi_neg_chain", 1'b1, 5'd4, 32'h1234_57fe);
        add_row(enc_addi(5'd5, 5'd0, 12'h800), "addi_x0_src", 1'b1, 5'd5, 32'hffff_f800);
        add_row(enc_addi(5'd0, 5'd1, 12'h005), "addi_to_x0", 1'b0, 5'd0, 32'h0);
        add_row(enc_upper(OPC_LUI, 5'd0, 20'habcde), "lui_to_x0", 1'b0, 5'd0, 32'h0);
        add_row({12'h001, 5'd1, 3'b100, 5'd6, 7'b0010011}, "op_imm_f3", 1'b0, 5'd0, 32'h0);
        add_row({7'b0, 5'd2, 5'd1, 3'b000, 5'd7, 7'b0110011}, "unknown_op", 1'b0, 5'd0, 32'h0);
        add_row(enc_addi(5'd6, 5'd5, 12'h064), "addi_chain_neg", 1'b1, 5'd6, 32'hffff_f864);
        add_row(enc_upper(OPC_AUIPC, 5'd7, 20'hfffff), "auipc_high", 1'b1, 5'd7, 32'hffff_f028);
        add_row(enc_addi(5'd8, 5'd7, 12'h000), "addi_mv", 1'b1, 5'd8, 32'hffff_f028);
        add_row(enc_upper(OPC_LUI, 5'd9, 20'h80000), "lui_msb", 1'b1, 5'd9, 32'h8000_0000);
    endtask

    initial begin
        wait (table_ready);
        #((tbl_inst.size() + NUM_RAND + 10) * CLK_PERIOD);
        $display("timeout: the core did not get through the program in time");
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed = 32'hdc94_cc67;
        inst = '0;
        table_ready = 1'b0;
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;
        end
        build_table();
        table_ready = 1'b1;

        // reset cycle with row 0 already on inst.
        @(posedge clk);
        #(DRIVE_DLY);
        inst = tbl_inst[0];
        #(SAMPLE_DLY);
        check_outputs("reset", core_pkg::RESET_PC, 1'b0, 1'b0, 5'd0, 32'h0);

        // instruction memory indexed by pc.
        for (int i = 0; i < tbl_inst.size(); i++) begin
            @(posedge clk);
            #(DRIVE_DLY);
            idx = pc >> 2;
            if (idx >= tbl_inst.size()) begin
                $display("pc %h points outside the program table", pc);
                $display("ERRORS FOUND");
                $fatal(1, "bad fetch address");
            end
            inst = tbl_inst[idx];
            #(SAMPLE_DLY);
            exp_pc = core_pkg::RESET_PC + 32'(4 * i);
            check_outputs(tbl_name[i], exp_pc, 1'b0, tbl_en[i], tbl_addr[i], tbl_data[i]);
            if (tbl_en[i]) begin
                model[tbl_addr[i]] = tbl_data[i];
            end
        end

        // random addi on top of the table state.
        for (int k = 0; k < NUM_RAND; k++) begin
            rnd = $random(seed);
            r_rd = rnd[4:0];
            r_rs1 = rnd[9:5];
            r_imm = rnd[21:10];
            exp_data = model[r_rs1] + {{20{r_imm[11]}}, r_imm};
            @(posedge clk);
            #(DRIVE_DLY);
            inst = enc_addi(r_rd, r_rs1, r_imm);
            #(SAMPLE_DLY);
            exp_pc = core_pkg::RESET_PC + 32'(4 * (tbl_inst.size() + k));
            check_outputs("rand_addi", exp_pc, 1'b0, r_rd != 5'd0, r_rd, exp_data);
            if (r_rd != 5'd0) begin
                model[r_rd] = exp_data;
            end
        end

        halt_pc = exp_pc + 32'd4;
        @(posedge clk);
        #(DRIVE_DLY);
        inst = EBREAK;
        #(SAMPLE_DLY);
        check_outputs("ebreak", halt_pc, 1'b0, 1'b0, 5'd0, 32'h0);

        // core frozen whatever comes next.
        for (int t = 0; t < HALT_TAIL; t++) begin
            @(posedge clk);
            #(DRIVE_DLY);
            case (t)
                0: inst = enc_upper(OPC_LUI, 5'd10, 20'h55555);
                1: inst = enc_addi(5'd11, 5'd1, 12'h007);
                2: inst = enc_upper(OPC_AUIPC, 5'd12, 20'h00010);
                default: inst = EBREAK;
            endcase
            #(SAMPLE_DLY);
            check_outputs("after_halt", halt_pc, 1'b1, 1'b0, 5'd0, 32'h0);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic arst_n
);

    localparam int HALF_PERIOD = 5;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge.
    initial begin
        arst_n = 1'b0;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
    end

endmodule
